//--- include/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// ==================================================
// Message and response geometry
// ==================================================
`define SPI_MSG_LEN         64
`define SPI_MSG_TYPE_LEN    8
`define SPI_MSG_ARG_LEN     56
`define SPI_RESP_LEN        64

// Nibbles per message, the leading dummy byte included
`define SPI_MSG_CYCLES      18

`define SPI_LED_W           4

// Type bit that marks a message expecting a response
`define SPI_TYPE_RESP_BIT   6

// ==================================================
// Message type codes, top type bit already forced
// ==================================================
`define SPI_TYPE_NOP        8'h80
`define SPI_TYPE_LED_SET    8'h81
`define SPI_TYPE_ECHO       8'hC0
`define SPI_TYPE_STATUS     8'hC1

// Field positions in the response and argument
`define SPI_RESP_ECHO_LSB       8
`define SPI_RESP_STAT_LED_MSB   63
`define SPI_RESP_STAT_LED_LSB   60
`define SPI_RESP_STAT_BAD_BIT   59
`define SPI_ARG_LED_MSB         3
`define SPI_ARG_LED_LSB         0

`endif

//--- src/spi_pkg.sv
`include "spi_consts.svh"

package spi_pkg;

    // ==================================================
    // Lane groups
    // ==================================================
    // Input lanes 3..0 carry one nibble per clock
    typedef logic [3:0] nibble_t;

    // All eight lanes in the response direction
    typedef logic [7:0] lanes_t;

    // ==================================================
    // Message and response words
    // ==================================================
    typedef logic [`SPI_MSG_TYPE_LEN-1:0] msg_type_t;

    typedef logic [`SPI_MSG_ARG_LEN-1:0] msg_arg_t;

    typedef logic [`SPI_RESP_LEN-1:0] resp_t;

    typedef logic [`SPI_LED_W-1:0] led_t;

    // Type occupies the top byte, argument follows
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } spi_msg_t;

    // Session states of the command controller
    typedef enum logic [1:0] {
        st_msg_in,
        st_decode,
        st_resp_out,
        st_idle
    } ctrl_state_t;

endpackage

//--- src/spi_msg_rx.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_msg_rx (
    input  logic              ice_st_spi_clk,
    input  logic              spi_cs,
    input  spi_pkg::nibble_t  spi_d_in,
    output spi_pkg::spi_msg_t msg,
    output logic              msg_valid
);

    localparam int CNT_W = $clog2(`SPI_MSG_CYCLES + 1);

    logic [CNT_W-1:0]        cycle_cnt;
    logic [`SPI_MSG_LEN-1:0] msg_sr;

    // ==================================================
    // Cycle counter
    // ==================================================
    // Loaded on every deselect, counts down one per captured nibble
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            cycle_cnt <= CNT_W'(`SPI_MSG_CYCLES);
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= (cycle_cnt == CNT_W'(1));
            if (cycle_cnt != '0) begin
                cycle_cnt <= cycle_cnt - CNT_W'(1);
            end
        end
    end

    // Nibble shift register, most significant nibble first.
    // The dummy byte falls off the top by the last capture
    always_ff @(posedge ice_st_spi_clk) begin
        if (cycle_cnt != '0) begin
            msg_sr <= {msg_sr[`SPI_MSG_LEN-5:0], spi_d_in};
        end
    end

    // Shifting has stopped once the strobe is out, so msg holds
    assign msg = msg_sr;

    // One message per selection, so the strobe cannot repeat
    msg_valid_single : assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg_valid |=> !msg_valid
    );

endmodule

//--- src/spi_cmd_ctrl.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_cmd_ctrl (
    input  logic              ice_st_spi_clk,
    input  logic              spi_cs,
    input  spi_pkg::spi_msg_t msg,
    input  logic              msg_valid,
    output spi_pkg::resp_t    resp,
    output logic              resp_load,
    output spi_pkg::led_t     led
);

    spi_pkg::ctrl_state_t state;
    spi_pkg::msg_type_t   type_fixed;
    spi_pkg::resp_t       resp_next;
    logic                 decode_en;
    logic                 type_has_resp;

    // Survive deselect, power up cleared
    spi_pkg::led_t led_q   = '0;
    logic          bad_cmd = 1'b0;

    // ==================================================
    // Message decode
    // ==================================================
    // The host cannot send the top type bit as one, so it is forced here
    assign type_fixed = {1'b1, msg.msg_type[`SPI_MSG_TYPE_LEN-2:0]};

    assign decode_en = msg_valid && (state == spi_pkg::st_msg_in);

    // Only known response types answer; unknown ones stay silent
    assign type_has_resp = (type_fixed == `SPI_TYPE_ECHO) ||
                           (type_fixed == `SPI_TYPE_STATUS);

    always_comb begin
        resp_next = '0;
        case (type_fixed)
            `SPI_TYPE_ECHO: begin
                resp_next[`SPI_RESP_LEN-1:`SPI_RESP_ECHO_LSB] = msg.arg;
            end
            `SPI_TYPE_STATUS: begin
                resp_next[`SPI_RESP_STAT_LED_MSB:`SPI_RESP_STAT_LED_LSB] = led_q;
                resp_next[`SPI_RESP_STAT_BAD_BIT] = bad_cmd;
            end
            default: begin
                resp_next = '0;
            end
        endcase
    end

    // ==================================================
    // Session FSM
    // ==================================================
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state     <= spi_pkg::st_msg_in;
            resp_load <= 1'b0;
        end else begin
            resp_load <= 1'b0;
            case (state)
                spi_pkg::st_msg_in: begin
                    if (msg_valid) begin
                        state     <= spi_pkg::st_decode;
                        resp_load <= type_has_resp;
                    end
                end
                spi_pkg::st_decode: begin
                    // resp_load is still high here when a response went out
                    state <= resp_load ? spi_pkg::st_resp_out : spi_pkg::st_idle;
                end
                default: begin
                    // Wait for deselect
                    state <= state;
                end
            endcase
        end
    end

    // Response word, captured together with the load strobe
    always_ff @(posedge ice_st_spi_clk) begin
        if (decode_en) begin
            resp <= resp_next;
        end
    end

    // LED and sticky error flag
    always_ff @(posedge ice_st_spi_clk) begin
        if (decode_en) begin
            case (type_fixed)
                `SPI_TYPE_LED_SET: begin
                    led_q <= msg.arg[`SPI_ARG_LED_MSB:`SPI_ARG_LED_LSB];
                end
                `SPI_TYPE_NOP, `SPI_TYPE_ECHO, `SPI_TYPE_STATUS: begin
                    led_q <= led_q;
                end
                default: begin
                    bad_cmd <= 1'b1;
                end
            endcase
        end
    end

    assign led = led_q;

    // A load always comes from a decoded message asking for a response
    resp_load_after_decode : assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        resp_load |-> ($past(decode_en) && $past(type_fixed[`SPI_TYPE_RESP_BIT]))
    );

endmodule

//--- src/spi_resp_tx.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_resp_tx (
    input  logic            ice_st_spi_clk,
    input  logic            spi_cs,
    input  spi_pkg::resp_t  resp,
    input  logic            resp_load,
    output spi_pkg::lanes_t spi_d_out,
    output logic            spi_d_out_en
);

    spi_pkg::resp_t resp_q;
    logic [15:0]    out_word;
    logic           shift_phase;

    // ==================================================
    // Output word sequencing
    // ==================================================
    // Even cycle loads a 16-bit word, odd cycle shifts it by a nibble
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            spi_d_out_en <= 1'b0;
            shift_phase  <= 1'b0;
            out_word     <= '0;
        end else if (resp_load) begin
            spi_d_out_en <= 1'b1;
            shift_phase  <= 1'b1;
            out_word     <= resp[`SPI_RESP_LEN-1 -: 16];
        end else if (spi_d_out_en) begin
            shift_phase <= !shift_phase;
            if (shift_phase) begin
                out_word <= {out_word[11:0], 4'b0000};
            end else begin
                out_word <= resp_q[`SPI_RESP_LEN-1 -: 16];
            end
        end
    end

    // Remaining response words; zeros fill in behind them
    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_load) begin
            resp_q <= {resp[`SPI_RESP_LEN-17:0], 16'h0000};
        end else if (spi_d_out_en && !shift_phase) begin
            resp_q <= {resp_q[`SPI_RESP_LEN-17:0], 16'h0000};
        end
    end

    // High lanes carry the upper byte, low lanes the lower byte
    assign spi_d_out = {out_word[15:12], out_word[7:4]};

    en_rise_needs_load : assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(spi_d_out_en) |-> $past(resp_load)
    );

endmodule

//--- src/spi_top.sv
`timescale 1ns/1ns

module spi_top (
    input  logic             ice_st_spi_clk,
    input  logic             spi_cs,
    input  spi_pkg::nibble_t spi_d_in,
    output spi_pkg::lanes_t  spi_d_out,
    output logic             spi_d_out_en,
    output spi_pkg::led_t    ice_led
);

    // ==================================================
    // Internal nets
    // ==================================================
    spi_pkg::spi_msg_t msg;
    logic              msg_valid;
    spi_pkg::resp_t    resp;
    logic              resp_load;

    // Message capture from the four input lanes
    spi_msg_rx u_msg_rx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .msg            (msg),
        .msg_valid      (msg_valid)
    );

    // Decode, LED and response assembly
    spi_cmd_ctrl u_cmd_ctrl (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .resp           (resp),
        .resp_load      (resp_load),
        .led            (ice_led)
    );

    // Response out on all eight lanes
    spi_resp_tx u_resp_tx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (resp),
        .resp_load      (resp_load),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en)
    );

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module tb_top;

    localparam logic [31:0] SEED = 32'h23c3_984d;

    logic             ice_st_spi_clk;
    logic             spi_cs;
    spi_pkg::nibble_t spi_d_in;
    spi_pkg::lanes_t  spi_d_out;
    logic             spi_d_out_en;
    spi_pkg::led_t    ice_led;

    // Reference model state
    spi_pkg::led_t model_led;
    logic          model_bad;

    spi_top dut (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en),
        .ice_led        (ice_led)
    );

    initial begin
        ice_st_spi_clk = 1'b0;
        forever #4 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    // ==================================================
    // Checking helpers
    // ==================================================
    task automatic fail_stop;
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
            fail_stop();
        end
    endtask

    task automatic check_en(input logic exp);
        check_value("spi_d_out_en", 64'(spi_d_out_en), 64'(exp));
    endtask

    // ==================================================
    // Random message fields
    // ==================================================
    // Keep the low seven type bits, randomize the top one
    function automatic spi_pkg::msg_type_t rand_top(input spi_pkg::msg_type_t code);
        logic [31:0] r;
        r = $urandom();
        return {r[0], code[6:0]};
    endfunction

    // Codes 82..BF and C2..FF are unknown once the top bit is forced
    function automatic spi_pkg::msg_type_t unknown_type();
        logic [31:0]        r;
        logic [31:0]        idx;
        spi_pkg::msg_type_t t;
        r   = $urandom();
        idx = r % 32'd124;
        if (idx < 32'd62) begin
            t = 8'h82 + idx[7:0];
        end else begin
            t = 8'hC2 + (idx[7:0] - 8'd62);
        end
        t[7] = r[31];
        return t;
    endfunction

    function automatic spi_pkg::msg_arg_t rand_arg();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $urandom();
        r2 = $urandom();
        return {r1[23:0], r2};
    endfunction

    // ==================================================
    // Response collection and deselect
    // ==================================================
    // Tail of the selection, 20 cycles after the last nibble
    task automatic collect_resp(input logic want_resp, input spi_pkg::resp_t exp_resp);
        int             tail;
        int             waited;
        int             base;
        logic           found;
        spi_pkg::resp_t got;
        tail   = 0;
        waited = 0;
        found  = 1'b0;
        got    = '0;
        if (want_resp) begin
            while (!found && waited < 40) begin
                @(negedge ice_st_spi_clk);
                tail++;
                if (spi_d_out_en) begin
                    found = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (!found) begin
                $display("timeout: spi_d_out_en did not rise within 40 cycles");
                fail_stop();
            end
            for (int c = 0; c < 8; c++) begin
                if (c > 0) begin
                    @(negedge ice_st_spi_clk);
                    tail++;
                    check_en(1'b1);
                end
                // Even cycle holds word bits 15..12 and 7..4, odd cycle 11..8 and 3..0
                base = 63 - 16 * (c / 2) - 4 * (c % 2);
                got[base -: 4]     = spi_d_out[7:4];
                got[base - 8 -: 4] = spi_d_out[3:0];
            end
            check_value("response", got, exp_resp);
        end
        while (tail < 20) begin
            @(negedge ice_st_spi_clk);
            tail++;
            check_en(want_resp);
            if (want_resp) begin
                check_value("spi_d_out", 64'(spi_d_out), 64'(0));
            end
        end
    endtask

    task automatic deselect;
        @(posedge ice_st_spi_clk);
        spi_cs   <= 1'b0;
        spi_d_in <= '0;
        repeat (2) begin
            @(negedge ice_st_spi_clk);
            check_en(1'b0);
            check_value("ice_led", 64'(ice_led), 64'(model_led));
        end
    endtask

    // ==================================================
    // One full selection with model update
    // ==================================================
    task automatic send_msg(input spi_pkg::msg_type_t code, input spi_pkg::msg_arg_t arg);
        spi_pkg::spi_msg_t  msg;
        logic [63:0]        bits;
        spi_pkg::msg_type_t fixed;
        spi_pkg::resp_t     exp_resp;
        logic               want_resp;
        msg.msg_type = code;
        msg.arg      = arg;
        bits         = msg;
        fixed        = code | 8'h80;
        want_resp    = 1'b0;
        exp_resp     = '0;
        case (fixed)
            `SPI_TYPE_NOP: begin
                want_resp = 1'b0;
            end
            `SPI_TYPE_LED_SET: begin
                model_led = arg[3:0];
            end
            `SPI_TYPE_ECHO: begin
                want_resp = 1'b1;
                exp_resp  = {arg, 8'h00};
            end
            `SPI_TYPE_STATUS: begin
                want_resp = 1'b1;
                exp_resp  = {model_led, model_bad, 59'd0};
            end
            default: begin
                model_bad = 1'b1;
            end
        endcase
        // Two dummy nibbles, then the message most significant first
        for (int i = 0; i < 18; i++) begin
            @(posedge ice_st_spi_clk);
            spi_cs <= 1'b1;
            if (i < 2) begin
                spi_d_in <= spi_pkg::nibble_t'($urandom());
            end else begin
                spi_d_in <= bits[63 - 4 * (i - 2) -: 4];
            end
            @(negedge ice_st_spi_clk);
            check_en(1'b0);
        end
        collect_resp(want_resp, exp_resp);
        deselect();
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int kind;
        spi_cs    = 1'b0;
        spi_d_in  = '0;
        model_led = '0;
        model_bad = 1'b0;
        void'($urandom(SEED));

        repeat (16) begin
            @(negedge ice_st_spi_clk);
            check_en(1'b0);
        end

        send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());
        repeat (3) send_msg(rand_top(`SPI_TYPE_ECHO), rand_arg());
        repeat (2) send_msg(rand_top(`SPI_TYPE_LED_SET), rand_arg());
        send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());
        repeat (2) send_msg(rand_top(`SPI_TYPE_NOP), rand_arg());
        send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());
        repeat (3) send_msg(unknown_type(), rand_arg());
        send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());

        // Random mix of all message kinds
        repeat (40) begin
            kind = int'($urandom() % 32'd5);
            case (kind)
                0: send_msg(rand_top(`SPI_TYPE_ECHO), rand_arg());
                1: send_msg(rand_top(`SPI_TYPE_LED_SET), rand_arg());
                2: send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());
                3: send_msg(rand_top(`SPI_TYPE_NOP), rand_arg());
                default: send_msg(unknown_type(), rand_arg());
            endcase
        end
        send_msg(rand_top(`SPI_TYPE_STATUS), rand_arg());

        $display("sim passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/spi_pkg.sv
src/spi_msg_rx.sv
src/spi_cmd_ctrl.sv
src/spi_resp_tx.sv
src/spi_top.sv
test/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the quad SPI command path testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_top \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without errors"
exit 0
